/* sched_macros.svh */
// Sizes are fixed here; widths must be kept consistent with the counts by hand
`ifndef SCHED_MACROS_SVH
`define SCHED_MACROS_SVH

// Receive ports and processing cores
`define SCHED_IF_COUNT 2
`define SCHED_CORE_COUNT 4
`define SCHED_SLOT_COUNT 8

// Slot numbers start at 1, so one extra bit over log2 of the slot count
`define SCHED_SLOT_WIDTH 4
`define SCHED_CORE_ID_WIDTH 2
`define SCHED_PORT_WIDTH 1

// Data beat and control message
`define SCHED_DATA_WIDTH 64
`define SCHED_CTRL_WIDTH 36

// Read-back value for registers that do not exist
`define SCHED_RD_DEFAULT 32'hFEFE_FEFE

`endif

/* sched_pkg.sv */
// Types follow the sizes in sched_macros.svh; host indexes are limited to 4 bits
`default_nettype none

`include "sched_macros.svh"

package sched_pkg;

  typedef struct packed {
    logic [`SCHED_DATA_WIDTH-1:0]   data;
    logic [`SCHED_DATA_WIDTH/8-1:0] keep;
    logic                           last;
  } data_beat_t;

  // Core and slot a packet is sent to
  typedef struct packed {
    logic [`SCHED_CORE_ID_WIDTH-1:0] core;
    logic [`SCHED_SLOT_WIDTH-1:0]    slot;
  } dest_tag_t;

  // One-cycle queue updates from the control path
  typedef struct packed {
    logic [`SCHED_CORE_COUNT-1:0] enq;
    logic [`SCHED_CORE_COUNT-1:0] init;
    logic [`SCHED_SLOT_WIDTH-1:0] slot;
  } slot_strobe_t;

  typedef struct packed {
    logic        wr;
    logic        to_if;
    logic        sched;
    logic [20:0] rsvd;
    logic [3:0]  index;
    logic [3:0]  reg_sel;
  } host_cmd_t;

  typedef enum logic [1:0] {STALL, FIRST, WAIT, MID} port_state_t;

  // Per-port status shown to the host
  typedef struct packed {
    port_state_t state;
    dest_tag_t   desc;
  } port_status_t;

endpackage

`default_nettype wire

/* sched_host_regs.sv */
// Writes act two edges after the command, reads show three edges later and hold
`timescale 1ns/10ps
`default_nettype none

`include "sched_macros.svh"

module sched_host_regs (
  input  wire                                                 clk,
  input  wire                                                 rst_r,
  input  wire sched_pkg::host_cmd_t                           host_cmd,
  input  wire [31:0]                                          host_wr_data,
  input  wire                                                 host_valid,
  input  wire [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0]  slot_counts,
  input  wire sched_pkg::port_status_t [`SCHED_IF_COUNT-1:0]  port_status,
  output logic [31:0]                                         host_rd_data,
  output logic [`SCHED_CORE_COUNT-1:0]                        enabled_cores,
  output logic [`SCHED_CORE_COUNT-1:0]                        income_cores,
  output logic [`SCHED_CORE_COUNT-1:0]                        slot_flush,
  output logic [`SCHED_IF_COUNT-1:0]                          release_desc
);
  import sched_pkg::*;

  host_cmd_t                       cmd_r;
  logic [31:0]                     wr_data_r;
  logic                            wr_r;
  logic [4:0]                      sel;
  logic [`SCHED_CORE_ID_WIDTH-1:0] core_idx;
  logic [`SCHED_PORT_WIDTH-1:0]    port_idx;
  port_status_t                    stat;
  logic [31:0]                     rd_mux;
  logic [31:0]                     rd_r;

  // Interface side in the top bit, register number below
  assign sel      = {cmd_r.to_if, cmd_r.reg_sel};
  assign core_idx = cmd_r.index[`SCHED_CORE_ID_WIDTH-1:0];
  assign port_idx = cmd_r.index[`SCHED_PORT_WIDTH-1:0];
  assign stat     = port_status[port_idx];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      cmd_r         <= '0;
      wr_r          <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      slot_flush    <= '0;
      release_desc  <= '0;
    end else begin
      wr_r <= host_valid && host_cmd.wr && host_cmd.sched;
      if (host_valid)
        cmd_r <= host_cmd;
      // Strobes last one cycle
      slot_flush   <= '0;
      release_desc <= '0;
      if (wr_r) begin
        case (sel)
          5'h00: begin
            // A disabled core cannot stay incoming
            enabled_cores <= wr_data_r[`SCHED_CORE_COUNT-1:0];
            income_cores  <= income_cores & wr_data_r[`SCHED_CORE_COUNT-1:0];
          end
          5'h01: income_cores <= wr_data_r[`SCHED_CORE_COUNT-1:0] & enabled_cores;
          5'h02: slot_flush   <= wr_data_r[`SCHED_CORE_COUNT-1:0];
          5'h12: release_desc <= wr_data_r[`SCHED_IF_COUNT-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (host_valid)
      wr_data_r <= host_wr_data;
  end

  always_comb begin
    case (sel)
      5'h00:   rd_mux = {{(32-`SCHED_CORE_COUNT){1'b0}}, enabled_cores};
      5'h01:   rd_mux = {{(32-`SCHED_CORE_COUNT){1'b0}}, income_cores};
      5'h03:   rd_mux = {{(32-`SCHED_SLOT_WIDTH){1'b0}}, slot_counts[core_idx]};
      5'h10:   rd_mux = {14'd0, stat.state,
                         {(8-`SCHED_CORE_ID_WIDTH){1'b0}}, stat.desc.core,
                         {(8-`SCHED_SLOT_WIDTH){1'b0}}, stat.desc.slot};
      default: rd_mux = `SCHED_RD_DEFAULT;
    endcase
  end

  // Two stages so the count and state muxes stay off the output
  always_ff @(posedge clk) begin
    rd_r         <= rd_mux;
    host_rd_data <= rd_r;
  end

endmodule

`default_nettype wire

/* slot_msg_decoder.sv */
// Only message types 0 and 3 act; all other types are consumed and dropped
`timescale 1ns/10ps
`default_nettype none

`include "sched_macros.svh"

module slot_msg_decoder (
  input  wire                                  clk,
  input  wire                                  rst_r,
  input  wire [`SCHED_CTRL_WIDTH-1:0]          ctrl_data,
  input  wire [`SCHED_CORE_ID_WIDTH-1:0]       ctrl_src,
  input  wire                                  ctrl_valid,
  output logic                                 ctrl_ready,
  output sched_pkg::slot_strobe_t              slot_strobe
);

  localparam logic [3:0] MSG_SLOT_RETURN = 4'd0;
  localparam logic [3:0] MSG_SLOT_INIT   = 4'd3;

  logic [`SCHED_CTRL_WIDTH-1:0]    msg_r;
  logic [`SCHED_CORE_ID_WIDTH-1:0] src_r;
  logic                            valid_r;
  logic [3:0]                      msg_type;
  logic [`SCHED_SLOT_WIDTH-1:0]    msg_slot;
  logic [`SCHED_CORE_COUNT-1:0]    src_onehot;

  // Every message type is taken
  assign ctrl_ready = 1'b1;

  always_ff @(posedge clk) begin
    if (rst_r)
      valid_r <= 1'b0;
    else
      valid_r <= ctrl_valid;
  end

  always_ff @(posedge clk) begin
    if (ctrl_valid) begin
      msg_r <= ctrl_data;
      src_r <= ctrl_src;
    end
  end

  // Type in the top nibble, slot value from bit 16
  assign msg_type = msg_r[`SCHED_CTRL_WIDTH-1 -: 4];
  assign msg_slot = msg_r[16 +: `SCHED_SLOT_WIDTH];

  always_comb begin
    src_onehot        = '0;
    src_onehot[src_r] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      slot_strobe <= '0;
    end else begin
      slot_strobe.enq  <= (valid_r && msg_type == MSG_SLOT_RETURN) ? src_onehot : '0;
      slot_strobe.init <= (valid_r && msg_type == MSG_SLOT_INIT) ? src_onehot : '0;
      slot_strobe.slot <= msg_slot;
    end
  end

endmodule

`default_nettype wire

/* slot_pool.sv */
// Init counts above the slot count are clipped; pushes into a full queue are lost
`timescale 1ns/10ps
`default_nettype none

`include "sched_macros.svh"

module slot_pool (
  input  wire                                                 clk,
  input  wire                                                 rst_r,
  input  wire sched_pkg::slot_strobe_t                        slot_strobe,
  input  wire [`SCHED_CORE_COUNT-1:0]                         enabled_cores,
  input  wire [`SCHED_CORE_COUNT-1:0]                         income_cores,
  input  wire [`SCHED_CORE_COUNT-1:0]                         slot_flush,
  input  wire                                                 desc_pop,
  output logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] slot_counts,
  output sched_pkg::dest_tag_t                                best_desc,
  output logic                                                best_valid
);
  import sched_pkg::*;

  localparam int PTR_W = $clog2(`SCHED_SLOT_COUNT);
  localparam logic [`SCHED_SLOT_WIDTH-1:0] FULL_CNT = `SCHED_SLOT_WIDTH'(`SCHED_SLOT_COUNT);

  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] head_slot;
  logic [`SCHED_CORE_COUNT-1:0]                        eligible;
  logic [`SCHED_CORE_COUNT-1:0]                        core_pop;
  logic [`SCHED_SLOT_WIDTH-1:0]                        init_cnt;
  logic [`SCHED_CORE_ID_WIDTH-1:0]                     best_core;
  logic [`SCHED_SLOT_WIDTH-1:0]                        best_cnt;

  assign init_cnt = (slot_strobe.slot > FULL_CNT) ? FULL_CNT : slot_strobe.slot;
  assign eligible = enabled_cores & income_cores;

  for (genvar i = 0; i < `SCHED_CORE_COUNT; i++) begin : g_queue
    logic [`SCHED_SLOT_WIDTH-1:0] mem [`SCHED_SLOT_COUNT];
    logic [PTR_W-1:0]             rd_ptr;
    logic [PTR_W-1:0]             wr_ptr;
    logic [`SCHED_SLOT_WIDTH-1:0] count;
    logic                         push;

    assign push        = slot_strobe.enq[i] && (count != FULL_CNT);
    assign core_pop[i] = desc_pop && (best_desc.core == `SCHED_CORE_ID_WIDTH'(i));

    always_ff @(posedge clk) begin
      if (rst_r || slot_flush[i]) begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        count  <= '0;
      end else if (slot_strobe.init[i]) begin
        // Slots 1..N sit at entries 0..N-1
        rd_ptr <= '0;
        wr_ptr <= init_cnt[PTR_W-1:0];
        count  <= init_cnt;
      end else begin
        if (push)
          wr_ptr <= wr_ptr + 1'b1;
        if (core_pop[i])
          rd_ptr <= rd_ptr + 1'b1;
        case ({push, core_pop[i]})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: ;
        endcase
      end
    end

    always_ff @(posedge clk) begin
      if (slot_strobe.init[i]) begin
        for (int j = 0; j < `SCHED_SLOT_COUNT; j++)
          mem[j] <= `SCHED_SLOT_WIDTH'(j + 1);
      end else if (push) begin
        mem[wr_ptr] <= slot_strobe.slot;
      end
    end

    assign head_slot[i]   = mem[rd_ptr];
    assign slot_counts[i] = count;
  end

  // Most free slots wins and a strict compare keeps the lowest index on ties
  always_comb begin
    best_core = '0;
    best_cnt  = '0;
    for (int k = 0; k < `SCHED_CORE_COUNT; k++) begin
      if (eligible[k] && slot_counts[k] > best_cnt) begin
        best_cnt  = slot_counts[k];
        best_core = `SCHED_CORE_ID_WIDTH'(k);
      end
    end
  end

  assign best_valid = (best_cnt != '0);
  assign best_desc  = '{core: best_core, slot: head_slot[best_core]};

endmodule

`default_nettype wire

/* port_dispatcher.sv */
// Data path is combinational; one descriptor is handed to one port per cycle
`timescale 1ns/10ps
`default_nettype none

`include "sched_macros.svh"

module port_dispatcher (
  input  wire                                                 clk,
  input  wire                                                 rst_r,
  input  wire sched_pkg::data_beat_t [`SCHED_IF_COUNT-1:0]    rx_beat,
  input  wire [`SCHED_IF_COUNT-1:0]                           rx_valid,
  input  wire [`SCHED_IF_COUNT-1:0]                           core_ready,
  input  wire sched_pkg::dest_tag_t                           best_desc,
  input  wire                                                 best_valid,
  input  wire [`SCHED_IF_COUNT-1:0]                           release_desc,
  output logic [`SCHED_IF_COUNT-1:0]                          rx_ready,
  output sched_pkg::data_beat_t [`SCHED_IF_COUNT-1:0]         core_beat,
  output sched_pkg::dest_tag_t [`SCHED_IF_COUNT-1:0]          core_dest,
  output logic [`SCHED_IF_COUNT-1:0][`SCHED_PORT_WIDTH-1:0]   core_port,
  output logic [`SCHED_IF_COUNT-1:0]                          core_valid,
  output logic                                                desc_pop,
  output sched_pkg::port_status_t [`SCHED_IF_COUNT-1:0]       port_status
);
  import sched_pkg::*;

  logic [`SCHED_IF_COUNT-1:0]   desc_req;
  logic [`SCHED_IF_COUNT-1:0]   grant;
  logic [`SCHED_PORT_WIDTH-1:0] last_grant;
  logic [`SCHED_PORT_WIDTH-1:0] grant_idx;
  logic                         grant_found;

  // Round robin search starts just after the last granted port
  always_comb begin
    int k;
    int cand;
    grant_idx   = last_grant;
    grant_found = 1'b0;
    for (k = 1; k <= `SCHED_IF_COUNT; k++) begin
      cand = (int'(last_grant) + k) % `SCHED_IF_COUNT;
      if (!grant_found && desc_req[cand]) begin
        grant_found = 1'b1;
        grant_idx   = cand[`SCHED_PORT_WIDTH-1:0];
      end
    end
  end

  assign desc_pop = best_valid && grant_found;

  // Port 0 goes first after reset
  always_ff @(posedge clk) begin
    if (rst_r)
      last_grant <= `SCHED_PORT_WIDTH'(`SCHED_IF_COUNT - 1);
    else if (desc_pop)
      last_grant <= grant_idx;
  end

  for (genvar p = 0; p < `SCHED_IF_COUNT; p++) begin : g_port
    port_state_t st;
    dest_tag_t   next_desc;
    dest_tag_t   cur_desc;
    logic        active;
    logic        beat_move;
    logic        last_move;

    assign active        = (st != STALL);
    assign rx_ready[p]   = core_ready[p] && active;
    assign core_valid[p] = rx_valid[p] && active;
    assign core_beat[p]  = rx_beat[p];
    assign core_port[p]  = `SCHED_PORT_WIDTH'(p);
    assign beat_move     = rx_valid[p] && rx_ready[p];
    assign last_move     = beat_move && rx_beat[p].last;
    assign desc_req[p]   = (st == STALL) || (st == WAIT) || ((st == FIRST) && beat_move);
    assign grant[p]      = desc_pop && (grant_idx == `SCHED_PORT_WIDTH'(p));

    // First beat carries the prefetched descriptor
    assign core_dest[p]   = (st == FIRST) ? next_desc : cur_desc;
    assign port_status[p] = '{state: st, desc: next_desc};

    always_ff @(posedge clk) begin
      if (rst_r) begin
        st <= STALL;
      end else begin
        case (st)
          STALL: if (grant[p]) st <= FIRST;
          FIRST: begin
            // A grant here comes with a moving beat
            if (beat_move) begin
              if (grant[p])
                st <= last_move ? FIRST : MID;
              else
                st <= last_move ? STALL : WAIT;
            end else if (release_desc[p]) begin
              st <= STALL;
            end
          end
          WAIT: begin
            if (grant[p] && last_move)
              st <= FIRST;
            else if (grant[p])
              st <= MID;
            else if (last_move)
              st <= STALL;
          end
          MID: begin
            if (last_move)
              st <= release_desc[p] ? STALL : FIRST;
            else if (release_desc[p])
              st <= WAIT;
          end
          default: st <= STALL;
        endcase
      end
    end

    always_ff @(posedge clk) begin
      if (rst_r)
        next_desc <= '0;
      else if (grant[p])
        next_desc <= best_desc;
    end

    // Packet start moves the prefetched descriptor to current
    always_ff @(posedge clk) begin
      if (st == FIRST && beat_move)
        cur_desc <= next_desc;
    end
  end

endmodule

`default_nettype wire

/* scheduler_top.sv */
// Sizes come from sched_macros.svh; ctrl_ready is always high
`timescale 1ns/10ps
`default_nettype none

`include "sched_macros.svh"

module scheduler_top (
  input  wire                                               clk,
  input  wire                                               rst_r,
  input  wire sched_pkg::data_beat_t [`SCHED_IF_COUNT-1:0]  rx_beat,
  input  wire [`SCHED_IF_COUNT-1:0]                         rx_valid,
  output logic [`SCHED_IF_COUNT-1:0]                        rx_ready,
  output sched_pkg::data_beat_t [`SCHED_IF_COUNT-1:0]       core_beat,
  output sched_pkg::dest_tag_t [`SCHED_IF_COUNT-1:0]        core_dest,
  output logic [`SCHED_IF_COUNT-1:0][`SCHED_PORT_WIDTH-1:0] core_port,
  output logic [`SCHED_IF_COUNT-1:0]                        core_valid,
  input  wire [`SCHED_IF_COUNT-1:0]                         core_ready,
  input  wire [`SCHED_CTRL_WIDTH-1:0]                       ctrl_data,
  input  wire [`SCHED_CORE_ID_WIDTH-1:0]                    ctrl_src,
  input  wire                                               ctrl_valid,
  output logic                                              ctrl_ready,
  input  wire sched_pkg::host_cmd_t                         host_cmd,
  input  wire [31:0]                                        host_wr_data,
  input  wire                                               host_valid,
  output logic [31:0]                                       host_rd_data
);
  import sched_pkg::*;

  slot_strobe_t                                        slot_strobe;
  logic [`SCHED_CORE_COUNT-1:0]                        enabled_cores;
  logic [`SCHED_CORE_COUNT-1:0]                        income_cores;
  logic [`SCHED_CORE_COUNT-1:0]                        slot_flush;
  logic [`SCHED_IF_COUNT-1:0]                          release_desc;
  logic [`SCHED_CORE_COUNT-1:0][`SCHED_SLOT_WIDTH-1:0] slot_counts;
  dest_tag_t                                           best_desc;
  logic                                                best_valid;
  logic                                                desc_pop;
  port_status_t [`SCHED_IF_COUNT-1:0]                  port_status;

  sched_host_regs host_regs_i (
    .clk, .rst_r, .host_cmd, .host_wr_data, .host_valid, .slot_counts,
    .port_status, .host_rd_data, .enabled_cores, .income_cores, .slot_flush,
    .release_desc
  );

  slot_msg_decoder msg_decoder_i (
    .clk, .rst_r, .ctrl_data, .ctrl_src, .ctrl_valid, .ctrl_ready, .slot_strobe
  );

  slot_pool slot_pool_i (
    .clk, .rst_r, .slot_strobe, .enabled_cores, .income_cores, .slot_flush,
    .desc_pop, .slot_counts, .best_desc, .best_valid
  );

  port_dispatcher dispatcher_i (
    .clk, .rst_r, .rx_beat, .rx_valid, .core_ready, .best_desc, .best_valid,
    .release_desc, .rx_ready, .core_beat, .core_dest, .core_port, .core_valid,
    .desc_pop, .port_status
  );

endmodule

`default_nettype wire

/* tb_scheduler.sv */
// Run from the project root so sched_golden.txt is found; back-pressure uses a fixed seed
`timescale 1ns/10ps
`default_nettype none

`include "sched_macros.svh"

module tb_scheduler;
  import sched_pkg::*;

  localparam int TIMEOUT = 200;
  localparam logic [`SCHED_DATA_WIDTH/8-1:0] KEEP_ALL = '1;

  logic                                              clk;
  logic                                              rst_r;
  data_beat_t [`SCHED_IF_COUNT-1:0]                  rx_beat;
  logic [`SCHED_IF_COUNT-1:0]                        rx_valid;
  logic [`SCHED_IF_COUNT-1:0]                        rx_ready;
  data_beat_t [`SCHED_IF_COUNT-1:0]                  core_beat;
  dest_tag_t [`SCHED_IF_COUNT-1:0]                   core_dest;
  logic [`SCHED_IF_COUNT-1:0][`SCHED_PORT_WIDTH-1:0] core_port;
  logic [`SCHED_IF_COUNT-1:0]                        core_valid;
  logic [`SCHED_IF_COUNT-1:0]                        core_ready;
  logic [`SCHED_CTRL_WIDTH-1:0]                      ctrl_data;
  logic [`SCHED_CORE_ID_WIDTH-1:0]                   ctrl_src;
  logic                                              ctrl_valid;
  logic                                              ctrl_ready;
  host_cmd_t                                         host_cmd;
  logic [31:0]                                       host_wr_data;
  logic                                              host_valid;
  logic [31:0]                                       host_rd_data;

  integer      seed;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  logic        aborted;
  string       line;
  int          fd;
  int          code;
  logic [7:0]  op;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] c;
  logic [63:0] d;

  scheduler_top scheduler_top_i (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  // Port number in the upper half, beat index below
  function automatic logic [63:0] beat_pattern(input logic [`SCHED_PORT_WIDTH-1:0] port,
                                               input int idx);
    beat_pattern = {16'hDA7A, 16'(port), 32'(idx)};
  endfunction

  // Read data is valid two edges after the command edge
  task automatic issue_cmd(input logic wr, input logic side, input logic [3:0] reg_sel,
                           input logic [3:0] index, input logic [31:0] data);
    @(negedge clk);
    host_cmd         = '0;
    host_cmd.wr      = wr;
    host_cmd.to_if   = side;
    host_cmd.sched   = 1'b1;
    host_cmd.index   = index;
    host_cmd.reg_sel = reg_sel;
    host_wr_data     = data;
    host_valid       = 1'b1;
    @(negedge clk);
    host_valid = 1'b0;
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic send_ctrl(input logic [3:0] msg_type,
                           input logic [`SCHED_CORE_ID_WIDTH-1:0] src, input logic [3:0] slot);
    int n;
    @(negedge clk);
    ctrl_data = '0;
    ctrl_data[`SCHED_CTRL_WIDTH-1 -: 4] = msg_type;
    ctrl_data[16 +: 4] = slot;
    ctrl_src   = src;
    ctrl_valid = 1'b1;
    #1;
    n = 0;
    while (!ctrl_ready && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!ctrl_ready) begin
      $display("Control message was never accepted by the DUT");
      aborted = 1'b1;
    end
    @(negedge clk);
    ctrl_valid = 1'b0;
  endtask

  task automatic send_packet(input logic [`SCHED_PORT_WIDTH-1:0] port, input int beats,
                             input logic [63:0] exp_core, input logic [63:0] exp_slot);
    int          sent;
    int          n;
    logic [31:0] rnd;
    sent = 0;
    n    = 0;
    while (sent < beats && n < TIMEOUT) begin
      @(negedge clk);
      rnd = $random(seed);
      core_ready[port]    = rnd[0];
      rx_valid[port]      = 1'b1;
      rx_beat[port].data  = beat_pattern(port, sent);
      rx_beat[port].keep  = '1;
      rx_beat[port].last  = (sent == beats - 1);
      #1;
      // Back-pressure holds the receive side
      if (!core_ready[port])
        check_value("rx_ready", 64'(rx_ready[port]), 64'd0);
      if (rx_ready[port]) begin
        // Beat moves on the coming edge
        check_value("core_valid", 64'(core_valid[port]), 64'd1);
        check_value("core_port", 64'(core_port[port]), 64'(port));
        check_value("core_dest.core", 64'(core_dest[port].core), exp_core);
        check_value("core_dest.slot", 64'(core_dest[port].slot), exp_slot);
        check_value("core_beat.data", core_beat[port].data, beat_pattern(port, sent));
        check_value("core_beat.keep", 64'(core_beat[port].keep), 64'(KEEP_ALL));
        check_value("core_beat.last", 64'(core_beat[port].last), 64'(sent == beats - 1));
        sent++;
        n = 0;
      end else begin
        n++;
      end
    end
    if (sent < beats) begin
      $display("Port %0d stopped accepting beats after %0d of %0d", port, sent, beats);
      aborted = 1'b1;
    end
    @(negedge clk);
    rx_valid[port] = 1'b0;
    core_ready     = '1;
  endtask

  // Stalled ports are offered a beat while the ready mask must hold
  task automatic wait_idle(input logic [`SCHED_IF_COUNT-1:0] exp_ready, input int hold);
    int n;
    @(negedge clk);
    rx_valid   = '0;
    core_ready = '1;
    #1;
    n = 0;
    while (rx_ready !== exp_ready && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (rx_ready !== exp_ready) begin
      $display("rx_ready never settled to %b, it is %b", exp_ready, rx_ready);
      aborted = 1'b1;
    end else begin
      for (int h = 0; h < hold; h++) begin
        @(negedge clk);
        rx_beat  = '0;
        rx_valid = ~exp_ready;
        #1;
        check_value("rx_ready", 64'(rx_ready), 64'(exp_ready));
        check_value("core_valid", 64'(core_valid), 64'd0);
      end
      @(negedge clk);
      rx_valid = '0;
    end
  endtask

  task automatic end_test(input int num);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %0d passed", num);
    end else begin
      $display("Test %0d failed with %0d errors", num, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  initial begin
    seed = 32'h9042;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    aborted = 1'b0;
    rst_r = 1'b1;
    rx_beat = '0;
    rx_valid = '0;
    core_ready = '1;
    ctrl_data = '0;
    ctrl_src = '0;
    ctrl_valid = 1'b0;
    host_cmd = '0;
    host_wr_data = '0;
    host_valid = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;

    fd = $fopen("sched_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open sched_golden.txt");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line.getc(0) == "#")
        continue;
      op = line.getc(0);
      a = '0;
      b = '0;
      c = '0;
      d = '0;
      code = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d);
      case (op)
        "W": issue_cmd(1'b1, a[0], b[3:0], c[3:0], d[31:0]);
        "R": begin
          issue_cmd(1'b0, a[0], b[3:0], c[3:0], 32'd0);
          check_value("host_rd_data", 64'(host_rd_data), d);
        end
        "C": send_ctrl(a[3:0], b[`SCHED_CORE_ID_WIDTH-1:0], c[3:0]);
        "P": send_packet(a[`SCHED_PORT_WIDTH-1:0], int'(b), c, d);
        "I": wait_idle(a[`SCHED_IF_COUNT-1:0], int'(b));
        "E": end_test(int'(a));
        default: begin
          $display("Unrecognized line in the golden file: %s", line);
          aborted = 1'b1;
        end
      endcase
    end
    if (fd != 0)
      $fclose(fd);
    errors += test_errors;

    $display("Tests run %0d, failing tests %0d, errors %0d", tests_run, tests_failed, errors);
    if (!aborted && errors == 0 && tests_failed == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sched_golden.txt */
# W side reg index data | R side reg index expected | C type src slot | I ready_mask hold
# P port beats exp_core exp_slot | E test_number ; all fields hex
I 0 4
R 0 0 0 0
R 0 1 0 0
R 0 5 0 FEFEFEFE
R 1 0 0 0
E 1
W 0 0 0 5
W 0 1 0 F
R 0 1 0 5
W 0 0 0 1
R 0 1 0 1
E 2
W 0 0 0 0
C 3 0 3
C 3 2 5
C 0 0 7
I 0 2
R 0 3 0 4
R 0 3 2 5
W 0 0 0 5
W 0 1 0 5
I 3 4
R 0 3 0 3
R 0 3 2 4
R 1 0 0 10201
R 1 0 1 10001
E 3
P 0 4 2 1
P 1 3 0 1
R 0 3 0 2
R 0 3 2 3
E 4
W 0 0 0 0
W 1 2 0 3
I 0 6
R 1 0 0 202
R 1 0 1 2
W 0 0 0 2
W 0 1 0 2
I 0 4
C 3 1 4
P 0 2 1 1
R 0 3 1 1
E 5
W 0 2 0 2
R 0 3 1 0
W 1 2 0 1
I 2 4
R 1 0 0 103
R 1 0 1 10102
E 6

/* tb.f */
+incdir+.
sched_pkg.sv
sched_host_regs.sv
slot_msg_decoder.sv
slot_pool.sv
port_dispatcher.sv
scheduler_top.sv
tb_scheduler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_scheduler
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary
PASS_MSG  ?= All tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) sched_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
